//--- source/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// ========================================
// Datapath sizes
// ========================================
`define CPU_XLEN        16
`define CPU_NUM_REGS    16
`define CPU_REG_IDX_W   4

// Primary opcodes in bits 15..13
`define CPU_OPC_RTYPE0  3'b000
`define CPU_OPC_RTYPE1  3'b001
`define CPU_OPC_LW      3'b010
`define CPU_OPC_SW      3'b011
`define CPU_OPC_BEQ     3'b100
`define CPU_OPC_J       3'b101

// ========================================
// Instruction field positions
// ========================================
`define CPU_OPC_MSB     15
`define CPU_OPC_LSB     13
`define CPU_RS_MSB      12
`define CPU_RS_LSB      9
`define CPU_RT_MSB      8
`define CPU_RT_LSB      5
`define CPU_RD_MSB      4
`define CPU_RD_LSB      1
`define CPU_FUNC_BIT    0
`define CPU_IMM_MSB     4
`define CPU_TGT_MSB     12

// Byte offset of the data space
`define CPU_DATA_OFFSET 16'h1000

`endif

//--- source/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

    // ========================================
    // Datapath types
    // ========================================

    // Core registers and memory words are signed
    typedef logic signed [`CPU_XLEN-1:0] cpu_word_t;

    typedef logic [`CPU_REG_IDX_W-1:0] cpu_reg_idx_t;

    // Decoded operation, one code per instruction
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_MULT,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_J
    } cpu_op_e;

endpackage

//--- source/cpu_fetch.sv
`timescale 1ns/1ps

module cpu_fetch (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_retire,
    input  logic              i_next_pc_valid,
    input  cpu_pkg::cpu_word_t i_next_pc,
    output logic              o_imem_req,
    output cpu_pkg::cpu_word_t o_imem_addr,
    input  logic              i_imem_valid,
    input  cpu_pkg::cpu_word_t i_imem_data,
    output logic              o_inst_valid,
    output cpu_pkg::cpu_word_t o_inst
);
    import cpu_pkg::*;

    cpu_word_t pc_q;
    cpu_word_t inst_q;
    logic      first_q;
    logic      pending_q;

    // Program counter, loaded by execute
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc_q <= '0;
        end
        else if (i_next_pc_valid)
        begin
            pc_q <= i_next_pc;
        end
    end

    // First fetch after reset, then one per retire
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            first_q      <= 1'b1;
            o_imem_req   <= 1'b0;
            pending_q    <= 1'b0;
            o_inst_valid <= 1'b0;
        end
        else
        begin
            first_q      <= 1'b0;
            o_imem_req   <= first_q || i_retire;
            o_inst_valid <= i_imem_valid;
            if (first_q || i_retire)
                pending_q <= 1'b1;
            else if (i_imem_valid)
                pending_q <= 1'b0;
        end
    end

    // Instruction register
    always_ff @(posedge clk)
    begin
        if (i_imem_valid)
            inst_q <= i_imem_data;
    end

    assign o_imem_addr = pc_q;
    assign o_inst      = inst_q;

    // A response must match an earlier request
    a_no_orphan_resp : assert property (
        @(posedge clk) disable iff (!rst_n)
        i_imem_valid |-> pending_q
    );

endmodule

//--- source/cpu_decode.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 i_inst_valid,
    input  cpu_pkg::cpu_word_t    i_inst,
    output cpu_pkg::cpu_reg_idx_t o_rs_idx,
    output cpu_pkg::cpu_reg_idx_t o_rt_idx,
    input  cpu_pkg::cpu_word_t    i_rs_data,
    input  cpu_pkg::cpu_word_t    i_rt_data,
    output logic                 o_dec_valid,
    output cpu_pkg::cpu_op_e      o_op,
    output cpu_pkg::cpu_word_t    o_op_a,
    output cpu_pkg::cpu_word_t    o_op_b,
    output cpu_pkg::cpu_word_t    o_imm,
    output cpu_pkg::cpu_word_t    o_target,
    output cpu_pkg::cpu_reg_idx_t o_dst,
    output logic                 o_wb_en
);
    import cpu_pkg::*;

    logic [2:0]   opcode;
    logic         func;
    cpu_reg_idx_t rd_idx;
    cpu_op_e      op_d;

    // Field split
    assign opcode   = i_inst[`CPU_OPC_MSB:`CPU_OPC_LSB];
    assign o_rs_idx = i_inst[`CPU_RS_MSB:`CPU_RS_LSB];
    assign o_rt_idx = i_inst[`CPU_RT_MSB:`CPU_RT_LSB];
    assign rd_idx   = i_inst[`CPU_RD_MSB:`CPU_RD_LSB];
    assign func     = i_inst[`CPU_FUNC_BIT];

    // Unused codes 110 and 111 fall into SLT
    always_comb
    begin
        case (opcode)
            `CPU_OPC_RTYPE0: op_d = func ? OP_SUB : OP_ADD;
            `CPU_OPC_RTYPE1: op_d = func ? OP_MULT : OP_SLT;
            `CPU_OPC_LW:     op_d = OP_LW;
            `CPU_OPC_SW:     op_d = OP_SW;
            `CPU_OPC_BEQ:    op_d = OP_BEQ;
            `CPU_OPC_J:      op_d = OP_J;
            default:         op_d = OP_SLT;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_dec_valid <= 1'b0;
            o_wb_en     <= 1'b0;
        end
        else
        begin
            o_dec_valid <= i_inst_valid;
            if (i_inst_valid)
                o_wb_en <= !(op_d inside {OP_SW, OP_BEQ, OP_J});
        end
    end

    // Operand and field latch
    always_ff @(posedge clk)
    begin
        if (i_inst_valid)
        begin
            o_op     <= op_d;
            o_op_a   <= i_rs_data;
            o_op_b   <= i_rt_data;
            o_imm    <= {{(`CPU_XLEN-`CPU_IMM_MSB-1){i_inst[`CPU_IMM_MSB]}},
                         i_inst[`CPU_IMM_MSB:0]};
            o_target <= {{(`CPU_XLEN-`CPU_TGT_MSB-1){1'b0}}, i_inst[`CPU_TGT_MSB:0]};
            // LW writes rt, R-types write rd
            o_dst    <= (op_d inside {OP_ADD, OP_SUB, OP_SLT, OP_MULT}) ? rd_idx : o_rt_idx;
        end
    end

endmodule

//--- source/cpu_regfile.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_regfile (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cpu_pkg::cpu_reg_idx_t i_rs_idx,
    input  cpu_pkg::cpu_reg_idx_t i_rt_idx,
    output cpu_pkg::cpu_word_t    o_rs_data,
    output cpu_pkg::cpu_word_t    o_rt_data,
    input  logic                 i_we,
    input  cpu_pkg::cpu_reg_idx_t i_wr_idx,
    input  cpu_pkg::cpu_word_t    i_wr_data
);
    import cpu_pkg::*;

    cpu_word_t core_r [`CPU_NUM_REGS];

    // ========================================
    // Write port
    // ========================================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CPU_NUM_REGS; i++)
            begin
                core_r[i] <= '0;
            end
        end
        else if (i_we)
        begin
            core_r[i_wr_idx] <= i_wr_data;
        end
    end

    // Read ports, combinational
    assign o_rs_data = core_r[i_rs_idx];
    assign o_rt_data = core_r[i_rt_idx];

endmodule

//--- source/cpu_execute.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_execute (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 i_dec_valid,
    input  cpu_pkg::cpu_op_e      i_op,
    input  cpu_pkg::cpu_word_t    i_op_a,
    input  cpu_pkg::cpu_word_t    i_op_b,
    input  cpu_pkg::cpu_word_t    i_imm,
    input  cpu_pkg::cpu_word_t    i_target,
    input  cpu_pkg::cpu_reg_idx_t i_dst,
    input  logic                 i_wb_en,
    output logic                 o_ex_valid,
    output cpu_pkg::cpu_op_e      o_op,
    output cpu_pkg::cpu_word_t    o_result,
    output cpu_pkg::cpu_word_t    o_store_data,
    output cpu_pkg::cpu_reg_idx_t o_dst,
    output logic                 o_wb_en,
    output cpu_pkg::cpu_word_t    o_next_pc
);
    import cpu_pkg::*;

    cpu_word_t pc_q;
    cpu_word_t eff_addr;
    cpu_word_t alu_d;
    cpu_word_t next_pc_d;

    // ========================================
    // ALU
    // ========================================
    assign eff_addr = i_op_a + i_imm;

    always_comb
    begin
        case (i_op)
            OP_ADD:       alu_d = i_op_a + i_op_b;
            OP_SUB:       alu_d = i_op_a - i_op_b;
            OP_SLT:       alu_d = (i_op_a < i_op_b) ? 16'sd1 : 16'sd0;
            OP_MULT:      alu_d = i_op_a * i_op_b;
            // Word index to byte address in data space
            OP_LW, OP_SW: alu_d = (eff_addr <<< 1) + `CPU_DATA_OFFSET;
            default:      alu_d = '0;
        endcase
    end

    // Branch and jump resolution
    always_comb
    begin
        if (i_op == OP_J)
            next_pc_d = i_target;
        else if (i_op == OP_BEQ && i_op_a == i_op_b)
            next_pc_d = pc_q + 16'sd1 + i_imm;
        else
            next_pc_d = pc_q + 16'sd1;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_ex_valid <= 1'b0;
            o_wb_en    <= 1'b0;
            pc_q       <= '0;
        end
        else
        begin
            o_ex_valid <= i_dec_valid;
            if (i_dec_valid)
            begin
                o_wb_en <= i_wb_en;
                pc_q    <= next_pc_d;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_dec_valid)
        begin
            o_op         <= i_op;
            o_result     <= alu_d;
            o_store_data <= i_op_b;
            o_dst        <= i_dst;
        end
    end

    assign o_next_pc = pc_q;

    // Decode must have produced a known operation
    a_op_known : assert property (
        @(posedge clk) disable iff (!rst_n)
        o_ex_valid |-> !$isunknown(o_op)
    );

endmodule

//--- source/cpu_memory.sv
`timescale 1ns/1ps

module cpu_memory (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 i_ex_valid,
    input  cpu_pkg::cpu_op_e      i_op,
    input  cpu_pkg::cpu_word_t    i_result,
    input  cpu_pkg::cpu_word_t    i_store_data,
    input  cpu_pkg::cpu_reg_idx_t i_dst,
    input  logic                 i_wb_en,
    output logic                 o_dmem_req,
    output logic                 o_dmem_we,
    output cpu_pkg::cpu_word_t    o_dmem_addr,
    output cpu_pkg::cpu_word_t    o_dmem_wdata,
    input  logic                 i_dmem_valid,
    input  cpu_pkg::cpu_word_t    i_dmem_rdata,
    output logic                 o_rf_we,
    output cpu_pkg::cpu_reg_idx_t o_rf_idx,
    output cpu_pkg::cpu_word_t    o_rf_data,
    output logic                 o_retire,
    output logic                 o_io_stall
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_RETIRE
    } mem_state_e;

    mem_state_e state_q;
    mem_state_e state_d;
    logic       is_mem;
    logic       issue;

    assign is_mem = (i_op == OP_LW) || (i_op == OP_SW);
    assign issue  = (state_q == ST_IDLE) && i_ex_valid && is_mem;

    // ========================================
    // Control FSM
    // ========================================
    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:
            begin
                if (i_ex_valid)
                    state_d = is_mem ? ST_WAIT : ST_RETIRE;
            end
            ST_WAIT:
            begin
                if (i_dmem_valid)
                    state_d = ST_RETIRE;
            end
            default:
            begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q    <= ST_IDLE;
            o_dmem_req <= 1'b0;
            o_dmem_we  <= 1'b0;
            o_rf_we    <= 1'b0;
            o_io_stall <= 1'b1;
        end
        else
        begin
            state_q    <= state_d;
            o_dmem_req <= issue;
            if (issue)
                o_dmem_we <= (i_op == OP_SW);
            o_rf_we    <= (state_d == ST_RETIRE) && i_wb_en;
            // Low only in the retire cycle
            o_io_stall <= (state_d != ST_RETIRE);
        end
    end

    // Access and writeback payload
    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            o_dmem_addr  <= i_result;
            o_dmem_wdata <= i_store_data;
        end
        if (state_d == ST_RETIRE)
        begin
            o_rf_idx  <= i_dst;
            o_rf_data <= (state_q == ST_WAIT) ? i_dmem_rdata : i_result;
        end
    end

    assign o_retire = (state_q == ST_RETIRE);

    // Data responses only while an access is outstanding
    a_resp_in_wait : assert property (
        @(posedge clk) disable iff (!rst_n)
        i_dmem_valid |-> (state_q == ST_WAIT)
    );

endmodule

//--- source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
    input  logic              clk,
    input  logic              rst_n,
    output logic              o_io_stall,
    output logic              o_imem_req,
    output cpu_pkg::cpu_word_t o_imem_addr,
    input  logic              i_imem_valid,
    input  cpu_pkg::cpu_word_t i_imem_data,
    output logic              o_dmem_req,
    output logic              o_dmem_we,
    output cpu_pkg::cpu_word_t o_dmem_addr,
    output cpu_pkg::cpu_word_t o_dmem_wdata,
    input  logic              i_dmem_valid,
    input  cpu_pkg::cpu_word_t i_dmem_rdata
);

    // Fetch to decode
    logic                  inst_valid;
    cpu_pkg::cpu_word_t    inst;

    // Decode and register file
    cpu_pkg::cpu_reg_idx_t rs_idx;
    cpu_pkg::cpu_reg_idx_t rt_idx;
    cpu_pkg::cpu_word_t    rs_data;
    cpu_pkg::cpu_word_t    rt_data;

    // Decode to execute
    logic                  dec_valid;
    cpu_pkg::cpu_op_e      dec_op;
    cpu_pkg::cpu_word_t    op_a;
    cpu_pkg::cpu_word_t    op_b;
    cpu_pkg::cpu_word_t    imm;
    cpu_pkg::cpu_word_t    target;
    cpu_pkg::cpu_reg_idx_t dec_dst;
    logic                  dec_wb_en;

    // Execute to memory and fetch
    logic                  ex_valid;
    cpu_pkg::cpu_op_e      ex_op;
    cpu_pkg::cpu_word_t    ex_result;
    cpu_pkg::cpu_word_t    ex_store_data;
    cpu_pkg::cpu_reg_idx_t ex_dst;
    logic                  ex_wb_en;
    cpu_pkg::cpu_word_t    next_pc;

    // Writeback and retire
    logic                  rf_we;
    cpu_pkg::cpu_reg_idx_t rf_idx;
    cpu_pkg::cpu_word_t    rf_data;
    logic                  retire;

    cpu_fetch u_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_retire        (retire),
        .i_next_pc_valid (ex_valid),
        .i_next_pc       (next_pc),
        .o_imem_req      (o_imem_req),
        .o_imem_addr     (o_imem_addr),
        .i_imem_valid    (i_imem_valid),
        .i_imem_data     (i_imem_data),
        .o_inst_valid    (inst_valid),
        .o_inst          (inst)
    );

    cpu_decode u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_inst_valid (inst_valid),
        .i_inst       (inst),
        .o_rs_idx     (rs_idx),
        .o_rt_idx     (rt_idx),
        .i_rs_data    (rs_data),
        .i_rt_data    (rt_data),
        .o_dec_valid  (dec_valid),
        .o_op         (dec_op),
        .o_op_a       (op_a),
        .o_op_b       (op_b),
        .o_imm        (imm),
        .o_target     (target),
        .o_dst        (dec_dst),
        .o_wb_en      (dec_wb_en)
    );

    cpu_regfile u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_rs_idx  (rs_idx),
        .i_rt_idx  (rt_idx),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_we      (rf_we),
        .i_wr_idx  (rf_idx),
        .i_wr_data (rf_data)
    );

    cpu_execute u_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_dec_valid  (dec_valid),
        .i_op         (dec_op),
        .i_op_a       (op_a),
        .i_op_b       (op_b),
        .i_imm        (imm),
        .i_target     (target),
        .i_dst        (dec_dst),
        .i_wb_en      (dec_wb_en),
        .o_ex_valid   (ex_valid),
        .o_op         (ex_op),
        .o_result     (ex_result),
        .o_store_data (ex_store_data),
        .o_dst        (ex_dst),
        .o_wb_en      (ex_wb_en),
        .o_next_pc    (next_pc)
    );

    cpu_memory u_memory (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_ex_valid   (ex_valid),
        .i_op         (ex_op),
        .i_result     (ex_result),
        .i_store_data (ex_store_data),
        .i_dst        (ex_dst),
        .i_wb_en      (ex_wb_en),
        .o_dmem_req   (o_dmem_req),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .i_dmem_valid (i_dmem_valid),
        .i_dmem_rdata (i_dmem_rdata),
        .o_rf_we      (rf_we),
        .o_rf_idx     (rf_idx),
        .o_rf_data    (rf_data),
        .o_retire     (retire),
        .o_io_stall   (o_io_stall)
    );

endmodule

//--- dv/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_tb;
    import cpu_pkg::*;

    localparam int MEM_WORDS  = 256;
    localparam int WAIT_LIMIT = 4000;

    logic      clk = 1'b0;
    logic      rst_n = 1'b0;
    logic      io_stall;
    logic      imem_req;
    cpu_word_t imem_addr;
    logic      imem_valid = 1'b0;
    cpu_word_t imem_data = '0;
    logic      dmem_req;
    logic      dmem_we;
    cpu_word_t dmem_addr;
    cpu_word_t dmem_wdata;
    logic      dmem_valid = 1'b0;
    cpu_word_t dmem_rdata = '0;

    // Memory models and the expected data image
    cpu_word_t imem [MEM_WORDS];
    cpu_word_t dmem [MEM_WORDS];
    cpu_word_t dmem_exp [MEM_WORDS];

    int        imem_wait = 0;
    cpu_word_t imem_addr_q;
    int        dmem_wait = 0;
    logic      dmem_we_q;
    cpu_word_t dmem_addr_q;
    cpu_word_t dmem_wdata_q;
    int        dmem_idx;

    int          imem_reqs = 0;
    int          dmem_reqs = 0;
    int          stall_pulses = 0;
    int          stall_low_cycles = 0;
    logic        stall_prev = 1'b1;
    int          error_count = 0;
    int          check_count = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    bit          slow_mem = 1'b0;
    logic [15:0] lfsr_q = 16'd38;

    always #2 clk = ~clk;

    cpu_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .o_io_stall   (io_stall),
        .o_imem_req   (imem_req),
        .o_imem_addr  (imem_addr),
        .i_imem_valid (imem_valid),
        .i_imem_data  (imem_data),
        .o_dmem_req   (dmem_req),
        .o_dmem_we    (dmem_we),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_wdata (dmem_wdata),
        .i_dmem_valid (dmem_valid),
        .i_dmem_rdata (dmem_rdata)
    );

    // ========================================
    // Helpers
    // ========================================

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Three bits give 1 to 8 cycles
    function automatic int draw_delay();
        int d;
        d = 0;
        for (int b = 0; b < 3; b++)
        begin
            d = (d << 1) | lfsr_q[15];
            lfsr_q = lfsr_next(lfsr_q);
        end
        return d + 1;
    endfunction

    function automatic cpu_word_t r_word(input logic [2:0] opc, input int rs, input int rt,
                                         input int rd, input logic func);
        return {opc, 4'(rs), 4'(rt), 4'(rd), func};
    endfunction

    function automatic cpu_word_t i_word(input logic [2:0] opc, input int rs, input int rt,
                                         input int imm);
        return {opc, 4'(rs), 4'(rt), 5'(imm)};
    endfunction

    function automatic cpu_word_t j_word(input int target);
        return {`CPU_OPC_J, 13'(target)};
    endfunction

    // (rs + imm) * 2 plus the data offset
    function automatic cpu_word_t byte_addr(input int base, input int imm);
        return 16'((base + imm) * 2 + 'h1000);
    endfunction

    // Word index in the data array or -1 outside it
    function automatic int data_index(input cpu_word_t addr);
        logic [15:0] off;
        off = addr - `CPU_DATA_OFFSET;
        if (off[0] || off >= 2 * MEM_WORDS)
            return -1;
        return int'(off >> 1);
    endfunction

    // ========================================
    // Memory models and monitor
    // ========================================
    always @(posedge clk)
    begin
        imem_valid <= 1'b0;
        if (!rst_n)
        begin
            imem_wait = 0;
        end
        else
        begin
            if (imem_req)
            begin
                assert (imem_wait == 0 && imem_addr >= 0 && imem_addr < MEM_WORDS)
                else
                begin
                    $display("Bad instruction request at %0t: overlapping or out of range",
                             $time);
                    error_count++;
                end
                imem_reqs++;
                imem_addr_q = imem_addr;
                imem_wait = slow_mem ? draw_delay() : 1;
            end
            if (imem_wait > 0)
            begin
                imem_wait--;
                if (imem_wait == 0)
                begin
                    imem_valid <= 1'b1;
                    imem_data  <= imem[imem_addr_q[7:0]];
                end
            end
        end
    end

    always @(posedge clk)
    begin
        dmem_valid <= 1'b0;
        if (!rst_n)
        begin
            dmem_wait = 0;
        end
        else
        begin
            if (dmem_req)
            begin
                assert (dmem_wait == 0)
                else
                begin
                    $display("Data request issued while another was outstanding at %0t", $time);
                    error_count++;
                end
                dmem_reqs++;
                dmem_we_q    = dmem_we;
                dmem_addr_q  = dmem_addr;
                dmem_wdata_q = dmem_wdata;
                dmem_wait = slow_mem ? draw_delay() : 1;
            end
            if (dmem_wait > 0)
            begin
                dmem_wait--;
                if (dmem_wait == 0)
                begin
                    dmem_idx = data_index(dmem_addr_q);
                    assert (dmem_idx >= 0)
                    else
                    begin
                        $display("Data access outside the data array at %0t, address %h",
                                 $time, dmem_addr_q);
                        error_count++;
                    end
                    if (dmem_idx >= 0 && dmem_we_q)
                        dmem[dmem_idx] = dmem_wdata_q;
                    else if (dmem_idx >= 0)
                        dmem_rdata <= dmem[dmem_idx];
                    dmem_valid <= 1'b1;
                end
            end
        end
    end

    // Completion pulse width
    always @(posedge clk)
    begin
        if (rst_n)
        begin
            if (!io_stall)
            begin
                stall_low_cycles++;
                if (stall_prev)
                    stall_pulses++;
            end
            assert (io_stall || stall_prev)
            else
            begin
                $display("Fail at %0t: io_stall low for two cycles in a row", $time);
                error_count++;
            end
        end
        stall_prev = io_stall;
    end

    // ========================================
    // Test steps
    // ========================================
    task automatic enter_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        @(posedge clk);
        // Unused program words jump to themselves
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            imem[i]     = j_word(i);
            dmem[i]     = {8'hd5, 8'(i)};
            dmem_exp[i] = dmem[i];
        end
    endtask

    task automatic leave_reset();
        repeat (4) @(posedge clk);
        imem_reqs        = 0;
        dmem_reqs        = 0;
        stall_pulses     = 0;
        stall_low_cycles = 0;
        rst_n <= 1'b1;
    endtask

    task automatic set_data(input int idx, input cpu_word_t value);
        dmem[idx]     = value;
        dmem_exp[idx] = value;
    endtask

    task automatic wait_retired(input int n, input string name);
        int cycles;
        cycles = 0;
        while (stall_pulses < n && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (stall_pulses >= n)
        else
        begin
            $display("Timeout in %s: only %0d of %0d instructions retired",
                     name, stall_pulses, n);
            error_count++;
        end
    endtask

    task automatic expect_equal(input int got, input int exp, input string what);
        check_count++;
        assert (got == exp)
        else
        begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_data(input string name);
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            check_count++;
            assert (dmem[i] === dmem_exp[i])
            else
            begin
                $display("Fail at %0t: %s data word %0d is %h, expected %h",
                         $time, name, i, dmem[i], dmem_exp[i]);
                error_count++;
            end
        end
    endtask

    // Retired count, fetch count and LW/SW count of one run
    task automatic finish_run(input string name, input int n_retire, input int n_mem);
        wait_retired(n_retire, name);
        expect_equal(imem_reqs, n_retire, {name, " fetch requests"});
        expect_equal(dmem_reqs, n_mem, {name, " data requests"});
        compare_data(name);
    endtask

    task automatic report_test(input string name, input int errs_before);
        string label;
        label = slow_mem ? {name, " with slow memories"} : name;
        tests_run++;
        if (error_count == errs_before)
        begin
            $display("Test %s: ok", label);
        end
        else
        begin
            tests_bad++;
            $display("Test %s: %0d errors", label, error_count - errs_before);
        end
    endtask

    // ========================================
    // Programs
    // ========================================
    task automatic arith_program();
        cpu_word_t a;
        cpu_word_t b;
        cpu_word_t c;
        a = 16'sd30000;
        b = -16'sd12345;
        c = 16'sd20000;
        set_data(0, a);
        set_data(1, b);
        set_data(2, c);
        imem[0] = i_word(`CPU_OPC_LW, 0, 1, 0);
        imem[1] = i_word(`CPU_OPC_LW, 0, 2, 1);
        imem[2] = i_word(`CPU_OPC_LW, 0, 3, 2);
        imem[3] = r_word(`CPU_OPC_RTYPE0, 1, 3, 4, 1'b0);
        imem[4] = r_word(`CPU_OPC_RTYPE0, 1, 2, 5, 1'b1);
        imem[5] = r_word(`CPU_OPC_RTYPE1, 1, 2, 6, 1'b0);
        imem[6] = r_word(`CPU_OPC_RTYPE1, 2, 1, 7, 1'b0);
        imem[7] = r_word(`CPU_OPC_RTYPE1, 1, 2, 8, 1'b1);
        imem[8] = r_word(`CPU_OPC_RTYPE0, 1, 2, 9, 1'b0);
        // r4..r9 go to words 8..13, then halt at 15
        for (int k = 0; k < 6; k++)
        begin
            imem[9 + k] = i_word(`CPU_OPC_SW, 0, 4 + k, 8 + k);
        end
        dmem_exp[8]  = 16'(int'(a) + int'(c));
        dmem_exp[9]  = 16'(int'(a) - int'(b));
        dmem_exp[10] = (int'(a) < int'(b)) ? 16'sd1 : 16'sd0;
        dmem_exp[11] = (int'(b) < int'(a)) ? 16'sd1 : 16'sd0;
        dmem_exp[12] = 16'(int'(a) * int'(b));
        dmem_exp[13] = 16'(int'(a) + int'(b));
    endtask

    task automatic branch_program();
        cpu_word_t marker;
        marker = 16'sh0a1c;
        set_data(0, 16'sd5);
        set_data(1, 16'sd5);
        set_data(2, 16'sd7);
        set_data(3, marker);
        imem[0] = i_word(`CPU_OPC_LW, 0, 1, 0);
        imem[1] = i_word(`CPU_OPC_LW, 0, 2, 1);
        imem[2] = i_word(`CPU_OPC_LW, 0, 3, 2);
        imem[3] = i_word(`CPU_OPC_LW, 0, 4, 3);
        imem[4] = i_word(`CPU_OPC_BEQ, 1, 2, 1);
        imem[5] = i_word(`CPU_OPC_SW, 0, 4, 10);
        imem[6] = i_word(`CPU_OPC_BEQ, 1, 3, 1);
        imem[7] = i_word(`CPU_OPC_SW, 0, 4, 11);
        imem[8] = i_word(`CPU_OPC_BEQ, 2, 1, 1);
        imem[9] = i_word(`CPU_OPC_SW, 0, 4, 12);
        imem[10] = i_word(`CPU_OPC_SW, 0, 4, 13);
        // 5 == 5 skips words 10 and 12, 5 != 7 falls through to word 11
        dmem_exp[11] = marker;
        dmem_exp[13] = marker;
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic arithmetic_ops();
        int errs_before;
        errs_before = error_count;
        enter_reset();
        arith_program();
        leave_reset();
        finish_run("arithmetic", 16, 9);
        report_test("arithmetic", errs_before);
    endtask

    task automatic load_store_addressing();
        int errs_before;
        errs_before = error_count;
        enter_reset();
        set_data(0, 16'sd20);
        set_data(4, 16'sh1234);
        set_data(35, -16'sd2);
        imem[0] = i_word(`CPU_OPC_LW, 0, 1, 0);
        imem[1] = i_word(`CPU_OPC_LW, 1, 2, -16);
        imem[2] = i_word(`CPU_OPC_LW, 1, 3, 15);
        imem[3] = i_word(`CPU_OPC_SW, 1, 2, -1);
        imem[4] = i_word(`CPU_OPC_SW, 1, 3, 7);
        imem[5] = i_word(`CPU_OPC_SW, 1, 1, -9);
        dmem_exp[data_index(byte_addr(20, -1))] = dmem_exp[data_index(byte_addr(20, -16))];
        dmem_exp[data_index(byte_addr(20, 7))]  = dmem_exp[data_index(byte_addr(20, 15))];
        dmem_exp[data_index(byte_addr(20, -9))] = 16'sd20;
        leave_reset();
        finish_run("addressing", 7, 6);
        report_test("addressing", errs_before);
    endtask

    task automatic branch_paths();
        int errs_before;
        errs_before = error_count;
        enter_reset();
        branch_program();
        leave_reset();
        finish_run("branches", 10, 6);
        report_test("branches", errs_before);
    endtask

    task automatic jump_skip();
        int errs_before;
        errs_before = error_count;
        enter_reset();
        set_data(0, 16'sh0c3c);
        imem[0] = i_word(`CPU_OPC_LW, 0, 1, 0);
        imem[1] = j_word(4);
        imem[2] = i_word(`CPU_OPC_SW, 0, 1, 5);
        imem[3] = i_word(`CPU_OPC_SW, 0, 1, 6);
        imem[4] = i_word(`CPU_OPC_SW, 0, 1, 7);
        dmem_exp[7] = 16'sh0c3c;
        leave_reset();
        finish_run("jump", 4, 2);
        report_test("jump", errs_before);
    endtask

    task automatic completion_pulse();
        int errs_before;
        errs_before = error_count;
        enter_reset();
        branch_program();
        @(negedge clk);
        expect_equal(io_stall, 1, "io_stall in reset");
        leave_reset();
        @(negedge clk);
        expect_equal(io_stall, 1, "io_stall after reset");
        finish_run("completion pulse", 10, 6);
        expect_equal(stall_low_cycles, stall_pulses, "io_stall low cycles");
        report_test("completion pulse", errs_before);
    endtask

    task automatic slow_memory_rerun();
        slow_mem = 1'b1;
        arithmetic_ops();
        branch_paths();
        slow_mem = 1'b0;
    endtask

    initial
    begin
        arithmetic_ops();
        load_store_addressing();
        branch_paths();
        jump_skip();
        completion_pulse();
        slow_memory_rerun();
        $display("Tests %0d, tests with errors %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, check_count, error_count);
        if (error_count == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- project.f
+incdir+source
source/cpu_pkg.sv
source/cpu_fetch.sv
source/cpu_decode.sv
source/cpu_regfile.sv
source/cpu_execute.sv
source/cpu_memory.sv
source/cpu_top.sv
dv/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu16

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/cpu_pkg.sv
      - source/cpu_fetch.sv
      - source/cpu_decode.sv
      - source/cpu_regfile.sv
      - source/cpu_execute.sv
      - source/cpu_memory.sv
      - source/cpu_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - dv/cpu_tb.sv
